// File: hw/cp0_if.sv
`timescale 1ns/100ps

interface cp0_if;

    cpu_pkg::Reg_addr_t rd_addr;
    cpu_pkg::Word_t     rd_data;

    // memory stage write, committed on the next edge
    logic               we;
    cpu_pkg::Reg_addr_t waddr;
    cpu_pkg::Word_t     wdata;

    modport alu  (output rd_addr, input rd_data, we, waddr, wdata);
    modport regs (input rd_addr, we, waddr, wdata, output rd_data);
    modport wr   (output we, waddr, wdata);

endinterface

// File: hw/cp0_regs.sv
`timescale 1ns/100ps

module cp0_regs (
    input  logic clk_i,
    input  logic rst_n_i,
    cp0_if.regs  bus
);

    cpu_pkg::Word_t status_q;
    cpu_pkg::Word_t cause_q;
    cpu_pkg::Word_t epc_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            status_q <= cpu_pkg::ZERO_WORD;
            cause_q  <= cpu_pkg::ZERO_WORD;
            epc_q    <= cpu_pkg::ZERO_WORD;
        end else if (bus.we) begin
            case (bus.waddr)
                cpu_pkg::CP0_STATUS: begin
                    status_q <= bus.wdata;
                end
                cpu_pkg::CP0_CAUSE: begin
                    // only the software interrupt bits take the new value
                    cause_q <= (bus.wdata & cpu_pkg::CP0_CAUSE_MASK) |
                               (cause_q & ~cpu_pkg::CP0_CAUSE_MASK);
                end
                cpu_pkg::CP0_EPC: begin
                    epc_q <= bus.wdata;
                end
                default: begin
                    status_q <= status_q;
                end
            endcase
        end
    end

    // unimplemented registers read as zero
    always_comb begin
        case (bus.rd_addr)
            cpu_pkg::CP0_STATUS: bus.rd_data = status_q;
            cpu_pkg::CP0_CAUSE:  bus.rd_data = cause_q;
            cpu_pkg::CP0_EPC:    bus.rd_data = epc_q;
            default:             bus.rd_data = cpu_pkg::ZERO_WORD;
        endcase
    end

endmodule

// File: hw/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] Word_t;
    typedef logic [63:0] Doubleword_t;
    typedef logic [4:0]  Reg_addr_t;
    typedef logic [31:0] Inst_addr_t;

    // operations seen by the execute stage
    typedef enum logic [5:0] {
        OP_NOP,
        OP_AND, OP_ANDI,
        OP_OR, OP_ORI,
        OP_XOR, OP_XORI,
        OP_NOR,
        OP_SLL, OP_SLLV,
        OP_SRL, OP_SRLV,
        OP_SRA, OP_SRAV,
        OP_LUI,
        OP_MOVN, OP_MOVZ,
        OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU,
        OP_SUB, OP_SUBU,
        OP_SLT, OP_SLTI, OP_SLTU, OP_SLTIU,
        OP_MUL, OP_MULT, OP_MULTU,
        OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO,
        OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW,
        OP_MFC0, OP_MTC0
    } oper_e;

    localparam Word_t ZERO_WORD = 32'h0000_0000;

    // coprocessor 0 register numbers
    localparam Reg_addr_t CP0_STATUS = 5'd12;
    localparam Reg_addr_t CP0_CAUSE  = 5'd13;
    localparam Reg_addr_t CP0_EPC    = 5'd14;

    // software may only touch the IP[1:0] bits of cause
    localparam Word_t CP0_CAUSE_MASK = 32'h0000_0300;

endpackage

// File: hw/ex_alu.sv
`timescale 1ns/100ps

module ex_alu (
    input  cpu_pkg::Inst_addr_t pc_i,
    input  cpu_pkg::oper_e      oper_i,
    input  cpu_pkg::Word_t      reg1_i,
    input  cpu_pkg::Word_t      reg2_i,
    input  logic                wreg_write_i,
    input  cpu_pkg::Reg_addr_t  wreg_addr_i,

    hilo_if.alu                 hilo,
    hilo_if.fwd                 mem_hilo,
    cp0_if.alu                  cp0,

    output logic                wreg_write_o,
    output cpu_pkg::Reg_addr_t  wreg_addr_o,
    output cpu_pkg::Word_t      wreg_data_o,
    output logic                whilo_o,
    output cpu_pkg::Word_t      hi_o,
    output cpu_pkg::Word_t      lo_o,
    output cpu_pkg::Word_t      mem_addr_o,
    output cpu_pkg::Word_t      mem_data_o,
    output logic                cp0_we_o,
    output cpu_pkg::Reg_addr_t  cp0_waddr_o,
    output cpu_pkg::Word_t      cp0_wdata_o
);

    cpu_pkg::Word_t       hi_fwd;
    cpu_pkg::Word_t       lo_fwd;
    cpu_pkg::Word_t       cp0_fwd;
    cpu_pkg::Word_t       add_res;
    cpu_pkg::Word_t       sub_res;
    logic                 signed_lt;
    logic                 unsigned_lt;
    logic                 mul_signed;
    cpu_pkg::Doubleword_t mul_a;
    cpu_pkg::Doubleword_t mul_b;
    cpu_pkg::Doubleword_t mul_res;

    // pending write in the memory stage wins over the committed pair
    assign hi_fwd = mem_hilo.whilo ? mem_hilo.wr_hi : hilo.hi;
    assign lo_fwd = mem_hilo.whilo ? mem_hilo.wr_lo : hilo.lo;

    // cp0 register number sits in the rd field, passed on reg2
    assign cp0.rd_addr = reg2_i[4:0];

    always_comb begin
        cp0_fwd = cp0.rd_data;
        if (cp0.we && (cp0.waddr == reg2_i[4:0])) begin
            case (cp0.waddr)
                cpu_pkg::CP0_STATUS,
                cpu_pkg::CP0_EPC: begin
                    cp0_fwd = cp0.wdata;
                end
                cpu_pkg::CP0_CAUSE: begin
                    cp0_fwd = (cp0.wdata & cpu_pkg::CP0_CAUSE_MASK) |
                              (cp0.rd_data & ~cpu_pkg::CP0_CAUSE_MASK);
                end
                default: begin
                    cp0_fwd = cp0.rd_data;
                end
            endcase
        end
    end

    assign add_res     = reg1_i + reg2_i;
    assign sub_res     = reg1_i - reg2_i;
    assign signed_lt   = (reg1_i[31] != reg2_i[31]) ? reg1_i[31] : sub_res[31];
    assign unsigned_lt = (reg1_i < reg2_i);

    // sign extend to 64 bits, low 64 bits of the product hold either result
    assign mul_signed = (oper_i != cpu_pkg::OP_MULTU);
    assign mul_a      = {{32{mul_signed & reg1_i[31]}}, reg1_i};
    assign mul_b      = {{32{mul_signed & reg2_i[31]}}, reg2_i};
    assign mul_res    = mul_a * mul_b;

    always_comb begin
        wreg_write_o = wreg_write_i;
        wreg_addr_o  = wreg_addr_i;
        wreg_data_o  = cpu_pkg::ZERO_WORD;
        whilo_o      = 1'b0;
        hi_o         = hi_fwd;
        lo_o         = lo_fwd;
        mem_addr_o   = cpu_pkg::ZERO_WORD;
        mem_data_o   = cpu_pkg::ZERO_WORD;
        cp0_we_o     = 1'b0;
        cp0_waddr_o  = 5'd0;
        cp0_wdata_o  = cpu_pkg::ZERO_WORD;

        case (oper_i)
            cpu_pkg::OP_AND, cpu_pkg::OP_ANDI: wreg_data_o = reg1_i & reg2_i;
            cpu_pkg::OP_OR, cpu_pkg::OP_ORI:   wreg_data_o = reg1_i | reg2_i;
            cpu_pkg::OP_XOR, cpu_pkg::OP_XORI: wreg_data_o = reg1_i ^ reg2_i;
            cpu_pkg::OP_NOR:                   wreg_data_o = ~(reg1_i | reg2_i);
            cpu_pkg::OP_SLL, cpu_pkg::OP_SLLV: wreg_data_o = reg2_i << reg1_i[4:0];
            cpu_pkg::OP_SRL, cpu_pkg::OP_SRLV: wreg_data_o = reg2_i >> reg1_i[4:0];
            cpu_pkg::OP_SRA, cpu_pkg::OP_SRAV: begin
                wreg_data_o = $signed(reg2_i) >>> reg1_i[4:0];
            end
            cpu_pkg::OP_LUI: wreg_data_o = {reg2_i[15:0], 16'h0000};
            cpu_pkg::OP_MOVN: begin
                wreg_data_o  = reg1_i;
                wreg_write_o = wreg_write_i & (reg2_i != cpu_pkg::ZERO_WORD);
            end
            cpu_pkg::OP_MOVZ: begin
                wreg_data_o  = reg1_i;
                wreg_write_o = wreg_write_i & (reg2_i == cpu_pkg::ZERO_WORD);
            end
            cpu_pkg::OP_ADD, cpu_pkg::OP_ADDI,
            cpu_pkg::OP_ADDU, cpu_pkg::OP_ADDIU: wreg_data_o = add_res;
            cpu_pkg::OP_SUB, cpu_pkg::OP_SUBU:   wreg_data_o = sub_res;
            cpu_pkg::OP_SLT, cpu_pkg::OP_SLTI:   wreg_data_o = {31'd0, signed_lt};
            cpu_pkg::OP_SLTU, cpu_pkg::OP_SLTIU: wreg_data_o = {31'd0, unsigned_lt};
            cpu_pkg::OP_MUL:  wreg_data_o = mul_res[31:0];
            cpu_pkg::OP_MFHI: wreg_data_o = hi_fwd;
            cpu_pkg::OP_MFLO: wreg_data_o = lo_fwd;
            cpu_pkg::OP_MULT, cpu_pkg::OP_MULTU,
            cpu_pkg::OP_MTHI, cpu_pkg::OP_MTLO: begin
                // these go to hi/lo, never to the register file
                whilo_o      = 1'b1;
                wreg_write_o = 1'b0;
                wreg_addr_o  = 5'd0;
                if (oper_i == cpu_pkg::OP_MTHI) begin
                    hi_o = reg1_i;
                end else if (oper_i == cpu_pkg::OP_MTLO) begin
                    lo_o = reg1_i;
                end else begin
                    {hi_o, lo_o} = mul_res;
                end
            end
            cpu_pkg::OP_JALR: wreg_data_o = pc_i + 32'd8;
            cpu_pkg::OP_JAL, cpu_pkg::OP_BLTZAL, cpu_pkg::OP_BGEZAL: begin
                wreg_write_o = 1'b1;
                wreg_data_o  = pc_i + 32'd8;
            end
            cpu_pkg::OP_LB, cpu_pkg::OP_LBU, cpu_pkg::OP_LH,
            cpu_pkg::OP_LHU, cpu_pkg::OP_LW: mem_addr_o = add_res;
            cpu_pkg::OP_SB, cpu_pkg::OP_SH, cpu_pkg::OP_SW: begin
                // store address already formed upstream
                mem_addr_o = reg1_i;
                mem_data_o = reg2_i;
            end
            cpu_pkg::OP_MTC0: begin
                cp0_we_o    = 1'b1;
                cp0_waddr_o = reg2_i[4:0];
                cp0_wdata_o = reg1_i;
            end
            cpu_pkg::OP_MFC0: wreg_data_o = cp0_fwd;
            default: begin
                wreg_data_o = cpu_pkg::ZERO_WORD;
            end
        endcase
    end

endmodule

// File: hw/ex_mem_reg.sv
`timescale 1ns/100ps

module ex_mem_reg (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  logic                wreg_write_i,
    input  cpu_pkg::Reg_addr_t  wreg_addr_i,
    input  cpu_pkg::Word_t      wreg_data_i,
    input  logic                whilo_i,
    input  cpu_pkg::Word_t      hi_i,
    input  cpu_pkg::Word_t      lo_i,
    input  cpu_pkg::Word_t      mem_addr_i,
    input  cpu_pkg::Word_t      mem_data_i,
    input  logic                cp0_we_i,
    input  cpu_pkg::Reg_addr_t  cp0_waddr_i,
    input  cpu_pkg::Word_t      cp0_wdata_i,
    input  cpu_pkg::Word_t      exception_type_i,
    input  logic                is_in_delayslot_i,
    input  cpu_pkg::Inst_addr_t pc_i,
    input  cpu_pkg::oper_e      oper_i,

    hilo_if.wr                  hilo_wr,
    cp0_if.wr                   cp0_wr,

    output logic                wreg_write_o,
    output cpu_pkg::Reg_addr_t  wreg_addr_o,
    output cpu_pkg::Word_t      wreg_data_o,
    output cpu_pkg::oper_e      oper_o,
    output cpu_pkg::Word_t      mem_addr_o,
    output cpu_pkg::Word_t      mem_data_o,
    output cpu_pkg::Word_t      exception_type_o,
    output logic                is_in_delayslot_o,
    output cpu_pkg::Inst_addr_t pc_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wreg_write_o      <= 1'b0;
            wreg_addr_o       <= 5'd0;
            wreg_data_o       <= cpu_pkg::ZERO_WORD;
            oper_o            <= cpu_pkg::OP_NOP;
            mem_addr_o        <= cpu_pkg::ZERO_WORD;
            mem_data_o        <= cpu_pkg::ZERO_WORD;
            exception_type_o  <= cpu_pkg::ZERO_WORD;
            is_in_delayslot_o <= 1'b0;
            pc_o              <= cpu_pkg::ZERO_WORD;
            hilo_wr.whilo     <= 1'b0;
            hilo_wr.wr_hi     <= cpu_pkg::ZERO_WORD;
            hilo_wr.wr_lo     <= cpu_pkg::ZERO_WORD;
            cp0_wr.we         <= 1'b0;
            cp0_wr.waddr      <= 5'd0;
            cp0_wr.wdata      <= cpu_pkg::ZERO_WORD;
        end else begin
            wreg_write_o      <= wreg_write_i;
            wreg_addr_o       <= wreg_addr_i;
            wreg_data_o       <= wreg_data_i;
            oper_o            <= oper_i;
            mem_addr_o        <= mem_addr_i;
            mem_data_o        <= mem_data_i;
            exception_type_o  <= exception_type_i;
            is_in_delayslot_o <= is_in_delayslot_i;
            pc_o              <= pc_i;
            // hi/lo and cp0 writes also feed the forwarding paths
            hilo_wr.whilo     <= whilo_i;
            hilo_wr.wr_hi     <= hi_i;
            hilo_wr.wr_lo     <= lo_i;
            cp0_wr.we         <= cp0_we_i;
            cp0_wr.waddr      <= cp0_waddr_i;
            cp0_wr.wdata      <= cp0_wdata_i;
        end
    end

endmodule

// File: hw/ex_stage_top.sv
`timescale 1ns/100ps

module ex_stage_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  cpu_pkg::Inst_addr_t pc_i,
    input  cpu_pkg::oper_e      oper_i,
    input  cpu_pkg::Word_t      reg1_i,
    input  cpu_pkg::Word_t      reg2_i,
    input  logic                wreg_write_i,
    input  cpu_pkg::Reg_addr_t  wreg_addr_i,
    input  cpu_pkg::Word_t      exception_type_i,
    input  logic                is_in_delayslot_i,

    output logic                wreg_write_o,
    output cpu_pkg::Reg_addr_t  wreg_addr_o,
    output cpu_pkg::Word_t      wreg_data_o,
    output cpu_pkg::oper_e      oper_o,
    output cpu_pkg::Word_t      mem_addr_o,
    output cpu_pkg::Word_t      mem_data_o,
    output cpu_pkg::Word_t      exception_type_o,
    output logic                is_in_delayslot_o,
    output cpu_pkg::Inst_addr_t pc_o,
    output cpu_pkg::Word_t      hi_o,
    output cpu_pkg::Word_t      lo_o
);

    hilo_if hilo_bus ();
    cp0_if  cp0_bus ();

    // execute unit results into the pipeline register
    logic               ex_wreg_write;
    cpu_pkg::Reg_addr_t ex_wreg_addr;
    cpu_pkg::Word_t     ex_wreg_data;
    logic               ex_whilo;
    cpu_pkg::Word_t     ex_hi;
    cpu_pkg::Word_t     ex_lo;
    cpu_pkg::Word_t     ex_mem_addr;
    cpu_pkg::Word_t     ex_mem_data;
    logic               ex_cp0_we;
    cpu_pkg::Reg_addr_t ex_cp0_waddr;
    cpu_pkg::Word_t     ex_cp0_wdata;

    ex_alu ex_alu_inst (
        .pc_i         (pc_i),
        .oper_i       (oper_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .wreg_write_i (wreg_write_i),
        .wreg_addr_i  (wreg_addr_i),
        .hilo         (hilo_bus.alu),
        .mem_hilo     (hilo_bus.fwd),
        .cp0          (cp0_bus.alu),
        .wreg_write_o (ex_wreg_write),
        .wreg_addr_o  (ex_wreg_addr),
        .wreg_data_o  (ex_wreg_data),
        .whilo_o      (ex_whilo),
        .hi_o         (ex_hi),
        .lo_o         (ex_lo),
        .mem_addr_o   (ex_mem_addr),
        .mem_data_o   (ex_mem_data),
        .cp0_we_o     (ex_cp0_we),
        .cp0_waddr_o  (ex_cp0_waddr),
        .cp0_wdata_o  (ex_cp0_wdata)
    );

    hilo_reg hilo_reg_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wr      (hilo_bus.regs)
    );

    cp0_regs cp0_regs_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (cp0_bus.regs)
    );

    ex_mem_reg ex_mem_reg_inst (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .wreg_write_i      (ex_wreg_write),
        .wreg_addr_i       (ex_wreg_addr),
        .wreg_data_i       (ex_wreg_data),
        .whilo_i           (ex_whilo),
        .hi_i              (ex_hi),
        .lo_i              (ex_lo),
        .mem_addr_i        (ex_mem_addr),
        .mem_data_i        (ex_mem_data),
        .cp0_we_i          (ex_cp0_we),
        .cp0_waddr_i       (ex_cp0_waddr),
        .cp0_wdata_i       (ex_cp0_wdata),
        .exception_type_i  (exception_type_i),
        .is_in_delayslot_i (is_in_delayslot_i),
        .pc_i              (pc_i),
        .oper_i            (oper_i),
        .hilo_wr           (hilo_bus.wr),
        .cp0_wr            (cp0_bus.wr),
        .wreg_write_o      (wreg_write_o),
        .wreg_addr_o       (wreg_addr_o),
        .wreg_data_o       (wreg_data_o),
        .oper_o            (oper_o),
        .mem_addr_o        (mem_addr_o),
        .mem_data_o        (mem_data_o),
        .exception_type_o  (exception_type_o),
        .is_in_delayslot_o (is_in_delayslot_o),
        .pc_o              (pc_o)
    );

    // committed pair, visible two cycles after the operation
    assign hi_o = hilo_bus.hi;
    assign lo_o = hilo_bus.lo;

endmodule

// File: hw/hilo_if.sv
`timescale 1ns/100ps

interface hilo_if;

    // committed register contents
    cpu_pkg::Word_t hi;
    cpu_pkg::Word_t lo;

    // write held in the memory stage
    logic           whilo;
    cpu_pkg::Word_t wr_hi;
    cpu_pkg::Word_t wr_lo;

    modport alu  (input hi, lo);
    modport fwd  (input whilo, wr_hi, wr_lo);
    modport regs (input whilo, wr_hi, wr_lo, output hi, lo);
    modport wr   (output whilo, wr_hi, wr_lo);

endinterface

// File: hw/hilo_reg.sv
`timescale 1ns/100ps

module hilo_reg (
    input  logic clk_i,
    input  logic rst_n_i,
    hilo_if.regs wr
);

    cpu_pkg::Word_t hi_q;
    cpu_pkg::Word_t lo_q;

    // commit happens one edge after the write reaches the memory stage
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hi_q <= cpu_pkg::ZERO_WORD;
            lo_q <= cpu_pkg::ZERO_WORD;
        end else if (wr.whilo) begin
            hi_q <= wr.wr_hi;
            lo_q <= wr.wr_lo;
        end
    end

    assign wr.hi = hi_q;
    assign wr.lo = lo_q;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_ex_stage \
    -f vlog.f -Mdir obj_dir -o tb_ex_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_ex_stage > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0

// File: verif/tb_ex_stage.sv
`timescale 1ns/100ps

module tb_ex_stage;

    // limit is close to four times the 540 or so cycles the tests take
    localparam int MAX_CYCLES = 2000;

    logic                clk_i = 1'b0;
    logic                rst_n_i;
    cpu_pkg::Inst_addr_t pc_i;
    cpu_pkg::oper_e      oper_i;
    cpu_pkg::Word_t      reg1_i;
    cpu_pkg::Word_t      reg2_i;
    logic                wreg_write_i;
    cpu_pkg::Reg_addr_t  wreg_addr_i;
    cpu_pkg::Word_t      exception_type_i;
    logic                is_in_delayslot_i;

    logic                wreg_write_o;
    cpu_pkg::Reg_addr_t  wreg_addr_o;
    cpu_pkg::Word_t      wreg_data_o;
    cpu_pkg::oper_e      oper_o;
    cpu_pkg::Word_t      mem_addr_o;
    cpu_pkg::Word_t      mem_data_o;
    cpu_pkg::Word_t      exception_type_o;
    logic                is_in_delayslot_o;
    cpu_pkg::Inst_addr_t pc_o;
    cpu_pkg::Word_t      hi_o;
    cpu_pkg::Word_t      lo_o;

    // side inputs applied with the next driven operation
    cpu_pkg::Inst_addr_t next_pc = '0;
    cpu_pkg::Word_t      next_exc = '0;
    logic                next_ds = 1'b0;
    int unsigned         cycles = 0;

    ex_stage_top ex_stage_top_inst (.*);

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Simulation failed");
            $fatal(1, "timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    task automatic check_eq(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic drive(cpu_pkg::oper_e op, cpu_pkg::Word_t a, cpu_pkg::Word_t b,
                         logic we, cpu_pkg::Reg_addr_t waddr);
        @(posedge clk_i);
        oper_i            <= op;
        reg1_i            <= a;
        reg2_i            <= b;
        wreg_write_i      <= we;
        wreg_addr_i       <= waddr;
        pc_i              <= next_pc;
        exception_type_i  <= next_exc;
        is_in_delayslot_i <= next_ds;
    endtask

    // idle slot and sample once the last operation is registered
    task automatic next_result();
        drive(cpu_pkg::OP_NOP, '0, '0, 1'b0, 5'd0);
        @(negedge clk_i);
    endtask

    function automatic cpu_pkg::Word_t expected_result(cpu_pkg::oper_e op,
                                                       cpu_pkg::Word_t a, cpu_pkg::Word_t b);
        case (op)
            cpu_pkg::OP_AND:  return a & b;
            cpu_pkg::OP_OR:   return a | b;
            cpu_pkg::OP_XOR:  return a ^ b;
            cpu_pkg::OP_NOR:  return ~(a | b);
            cpu_pkg::OP_SLL:  return b << a[4:0];
            cpu_pkg::OP_SRL:  return b >> a[4:0];
            cpu_pkg::OP_SRA:  return $signed(b) >>> a[4:0];
            cpu_pkg::OP_LUI:  return {b[15:0], 16'h0000};
            cpu_pkg::OP_ADD:  return a + b;
            cpu_pkg::OP_SUB:  return a - b;
            cpu_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            cpu_pkg::OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:          return '0;
        endcase
    endfunction

    task automatic run_alu_ops();
        cpu_pkg::oper_e     ops[12];
        cpu_pkg::Word_t     a;
        cpu_pkg::Word_t     b;
        cpu_pkg::Reg_addr_t waddr;
        logic               we;
        ops = '{cpu_pkg::OP_AND, cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_NOR,
                cpu_pkg::OP_SLL, cpu_pkg::OP_SRL, cpu_pkg::OP_SRA, cpu_pkg::OP_LUI,
                cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_SLT, cpu_pkg::OP_SLTU};
        foreach (ops[i]) begin
            repeat (20) begin
                a = $urandom();
                b = $urandom();
                waddr = 5'($urandom());
                we = 1'($urandom());
                drive(ops[i], a, b, we, waddr);
                next_result();
                check_eq(ops[i].name(), expected_result(ops[i], a, b), wreg_data_o);
                check_eq(ops[i].name(), 32'(we), 32'(wreg_write_o));
                check_eq(ops[i].name(), 32'(waddr), 32'(wreg_addr_o));
            end
        end
    endtask

    task automatic run_movn_movz();
        cpu_pkg::oper_e op;
        cpu_pkg::Word_t a;
        cpu_pkg::Word_t b;
        logic           cond;
        for (int k = 0; k < 4; k++) begin
            op = (k < 2) ? cpu_pkg::OP_MOVN : cpu_pkg::OP_MOVZ;
            a = $urandom();
            b = (k % 2 == 0) ? '0 : ($urandom() | 32'h1);
            cond = (op == cpu_pkg::OP_MOVN) ? (b != '0) : (b == '0);
            drive(op, a, b, 1'b1, 5'd3);
            next_result();
            check_eq(op.name(), 32'(cond), 32'(wreg_write_o));
            check_eq(op.name(), a, wreg_data_o);
        end
    endtask

    task automatic write_hilo(string name, cpu_pkg::oper_e op, cpu_pkg::Word_t a,
                              cpu_pkg::Word_t b, cpu_pkg::Word_t exp_hi,
                              cpu_pkg::Word_t exp_lo);
        drive(op, a, b, 1'b1, 5'd11);
        next_result();
        check_eq(name, 32'd0, 32'(wreg_write_o));
        next_result();
        check_eq(name, exp_hi, hi_o);
        check_eq(name, exp_lo, lo_o);
    endtask

    task automatic run_hilo();
        cpu_pkg::Word_t a;
        cpu_pkg::Word_t b;
        cpu_pkg::Word_t c;
        cpu_pkg::Word_t d;
        logic [63:0]    prod;
        a = $urandom();
        b = $urandom();
        c = $urandom();
        d = $urandom();
        prod = longint'($signed(a)) * longint'($signed(b));
        // mfhi right behind mult sees the high word from the memory stage
        drive(cpu_pkg::OP_MULT, a, b, 1'b1, 5'd9);
        drive(cpu_pkg::OP_MFHI, '0, '0, 1'b1, 5'd10);
        @(negedge clk_i);
        check_eq("mult", 32'd0, 32'(wreg_write_o));
        next_result();
        check_eq("mfhi forwarded", prod[63:32], wreg_data_o);
        check_eq("mult hi", prod[63:32], hi_o);
        check_eq("mult lo", prod[31:0], lo_o);
        drive(cpu_pkg::OP_MUL, a, b, 1'b1, 5'd12);
        next_result();
        check_eq("mul", prod[31:0], wreg_data_o);
        check_eq("mul", 32'd1, 32'(wreg_write_o));
        prod = {32'd0, a} * {32'd0, b};
        write_hilo("multu", cpu_pkg::OP_MULTU, a, b, prod[63:32], prod[31:0]);
        write_hilo("mthi", cpu_pkg::OP_MTHI, c, '0, c, prod[31:0]);
        write_hilo("mtlo", cpu_pkg::OP_MTLO, d, '0, c, d);
    endtask

    task automatic run_cp0();
        cpu_pkg::Word_t v;
        v = $urandom() | 32'h1;
        drive(cpu_pkg::OP_MTC0, v, 32'(cpu_pkg::CP0_STATUS), 1'b0, 5'd0);
        drive(cpu_pkg::OP_MFC0, '0, 32'(cpu_pkg::CP0_STATUS), 1'b1, 5'd4);
        next_result();
        check_eq("mfc0 status forwarded", v, wreg_data_o);
        drive(cpu_pkg::OP_MFC0, '0, 32'(cpu_pkg::CP0_STATUS), 1'b1, 5'd4);
        next_result();
        check_eq("mfc0 status", v, wreg_data_o);
        // only ip[1:0] of cause can be written
        drive(cpu_pkg::OP_MTC0, 32'hffff_ffff, 32'(cpu_pkg::CP0_CAUSE), 1'b0, 5'd0);
        drive(cpu_pkg::OP_MFC0, '0, 32'(cpu_pkg::CP0_CAUSE), 1'b1, 5'd5);
        next_result();
        check_eq("mfc0 cause forwarded", 32'h0000_0300, wreg_data_o);
        drive(cpu_pkg::OP_MFC0, '0, 32'(cpu_pkg::CP0_CAUSE), 1'b1, 5'd5);
        next_result();
        check_eq("mfc0 cause", 32'h0000_0300, wreg_data_o);
        drive(cpu_pkg::OP_MTC0, v, 32'd5, 1'b0, 5'd0);
        drive(cpu_pkg::OP_MFC0, '0, 32'd5, 1'b1, 5'd6);
        next_result();
        check_eq("mfc0 unimplemented", 32'd0, wreg_data_o);
    endtask

    task automatic run_mem_and_link();
        cpu_pkg::Word_t a;
        cpu_pkg::Word_t b;
        cpu_pkg::Word_t jal_pc;
        cpu_pkg::Word_t exc;
        a = $urandom();
        b = $urandom();
        drive(cpu_pkg::OP_LW, a, b, 1'b1, 5'd8);
        next_result();
        check_eq("lw address", a + b, mem_addr_o);
        drive(cpu_pkg::OP_SW, a, b, 1'b0, 5'd0);
        next_result();
        check_eq("sw address", a, mem_addr_o);
        check_eq("sw data", b, mem_data_o);
        jal_pc = $urandom() & 32'hffff_fffc;
        exc = $urandom();
        next_pc = jal_pc;
        next_exc = exc;
        next_ds = 1'b1;
        drive(cpu_pkg::OP_JAL, '0, '0, 1'b0, 5'd31);
        next_pc = '0;
        next_exc = '0;
        next_ds = 1'b0;
        next_result();
        check_eq("jal write", 32'd1, 32'(wreg_write_o));
        check_eq("jal link", jal_pc + 32'd8, wreg_data_o);
        check_eq("pc pass", jal_pc, pc_o);
        check_eq("exception pass", exc, exception_type_o);
        check_eq("delayslot pass", 32'd1, 32'(is_in_delayslot_o));
        check_eq("oper pass", 32'(cpu_pkg::OP_JAL), 32'(oper_o));
    endtask

    task automatic run_mid_reset();
        next_pc = 32'h0000_0100;
        next_exc = $urandom() | 32'h1;
        next_ds = 1'b1;
        drive(cpu_pkg::OP_JAL, $urandom(), $urandom(), 1'b1, 5'd31);
        rst_n_i <= 1'b0;
        next_pc = '0;
        next_exc = '0;
        next_ds = 1'b0;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_eq("reset write", 32'd0, 32'(wreg_write_o));
        check_eq("reset addr", 32'd0, 32'(wreg_addr_o));
        check_eq("reset data", 32'd0, wreg_data_o);
        check_eq("reset pc", 32'd0, pc_o);
        check_eq("reset exception", 32'd0, exception_type_o);
        check_eq("reset delayslot", 32'd0, 32'(is_in_delayslot_o));
        check_eq("reset oper", 32'(cpu_pkg::OP_NOP), 32'(oper_o));
        check_eq("reset hi", 32'd0, hi_o);
        check_eq("reset lo", 32'd0, lo_o);
        drive(cpu_pkg::OP_MFC0, '0, 32'(cpu_pkg::CP0_STATUS), 1'b1, 5'd4);
        next_result();
        check_eq("reset status", 32'd0, wreg_data_o);
    endtask

    initial begin
        void'($urandom(35));
        rst_n_i = 1'b0;
        pc_i = '0;
        oper_i = cpu_pkg::OP_NOP;
        reg1_i = '0;
        reg2_i = '0;
        wreg_write_i = 1'b0;
        wreg_addr_i = '0;
        exception_type_i = '0;
        is_in_delayslot_i = 1'b0;
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        run_alu_ops();
        run_movn_movz();
        run_hilo();
        run_cp0();
        run_mem_and_link();
        run_mid_reset();
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: vlog.f
hw/cpu_pkg.sv
hw/hilo_if.sv
hw/cp0_if.sv
hw/ex_alu.sv
hw/hilo_reg.sv
hw/cp0_regs.sv
hw/ex_mem_reg.sv
hw/ex_stage_top.sv
verif/tb_ex_stage.sv
